//--- hdl/gteReg_defines.svh
`ifndef GTE_REG_DEFINES_SVH
`define GTE_REG_DEFINES_SVH

// ----------------------------------------
// Word and index widths
// ----------------------------------------
`define GTE_WORD_W     32   // CPU data word
`define GTE_HALF_W     16   // Low half, kept on promotion
`define GTE_IDX_W      5    // Index inside one file
`define GTE_REG_COUNT  32   // Entries per file

// ----------------------------------------
// Control register promotion
// ----------------------------------------
// Upper half is a copy of bit 15
`define GTE_CT_R33     4    // Rotation matrix element 33
`define GTE_CT_L33     12   // Light matrix element 33
`define GTE_CT_LB3     20   // Light colour matrix element 3

// Upper half reads as zero, inclusive bounds
`define GTE_CT_ZLO     26   // H
`define GTE_CT_ZHI     30   // ZSF4

`endif

//--- hdl/gteRegPkg.sv
`include "gteReg_defines.svh"

package gteRegPkg;

	// CPU register ID, bit 5 picks the control file
	typedef struct packed {
		logic                  isCtrl;
		logic [`GTE_IDX_W-1:0] idx;
	} gteRegAddr_t;

	// Data registers with special read or write handling
	typedef enum logic [`GTE_IDX_W-1:0] {
		VZ0  = 5'd1,  VZ1  = 5'd3,  VZ2  = 5'd5,
		OTZ  = 5'd7,
		IR0  = 5'd8,  IR1  = 5'd9,  IR2  = 5'd10, IR3  = 5'd11,
		SXY0 = 5'd12, SXY1 = 5'd13, SXY2 = 5'd14,
		SXYP = 5'd15,  // Push port of the screen XY FIFO
		SZ0  = 5'd16, SZ1  = 5'd17, SZ2  = 5'd18, SZ3  = 5'd19,
		IRGB = 5'd28, ORGB = 5'd29,
		LZCS = 5'd30,  // Lead count source
		LZCR = 5'd31   // Lead count result
	} gteDataReg_e;

endpackage

//--- hdl/gteRegFile.sv
`include "gteReg_defines.svh"

module gteRegFile (
	input  logic                   i_clk,
	// Read side
	input  logic                   i_rd,
	input  logic [`GTE_IDX_W-1:0]  i_rdIdx,
	output logic [`GTE_WORD_W-1:0] o_rdData,
	// Write side
	input  logic                   i_wr,
	input  logic [`GTE_IDX_W-1:0]  i_wrIdx,
	input  logic [`GTE_WORD_W-1:0] i_wrData
);

	logic [`GTE_WORD_W-1:0] mem [0:`GTE_REG_COUNT-1];

	always_ff @(posedge i_clk) begin
		if (i_wr)
			mem[i_wrIdx] <= i_wrData;
		// Output register keeps last read word
		if (i_rd)
			o_rdData <= mem[i_rdIdx];
	end

	// Write address comes from the CPU port, never X on a write
	wrIdxKnown : assert property (@(posedge i_clk)
		i_wr |-> !$isunknown(i_wrIdx))
		else $error("register file write with unknown index");

endmodule

//--- hdl/gteLeadCount.sv
`include "gteReg_defines.svh"

module gteLeadCount (
	input  logic [`GTE_WORD_W-1:0] i_value,
	output logic [5:0]             o_count   // 1..32
);

	logic [`GTE_WORD_W-1:0] diff;   // Bits differing from the sign

	// Leading copies of bit 31 become leading zeros
	assign diff = i_value ^ {`GTE_WORD_W{i_value[`GTE_WORD_W-1]}};

	always_comb begin
		o_count = 6'd32;  // All zeros or all ones
		// Ascending scan, highest differing bit wins
		for (int i = 0; i < `GTE_WORD_W - 1; i++) begin
			if (diff[i])
				o_count = 6'(`GTE_WORD_W - 1 - i);
		end
	end

endmodule

//--- hdl/gteSpecialRegs.sv
`include "gteReg_defines.svh"

module gteSpecialRegs (
	input  logic                    i_clk,
	input  logic                    i_arstN,
	// Data register write from CPU
	input  logic                    i_wr,
	input  gteRegPkg::gteDataReg_e  i_idx,
	input  logic [`GTE_WORD_W-1:0]  i_wrData,
	// Screen XY FIFO
	output logic [`GTE_WORD_W-1:0]  o_sxy0,
	output logic [`GTE_WORD_W-1:0]  o_sxy1,
	output logic [`GTE_WORD_W-1:0]  o_sxy2,
	// IR0..IR3, low half only
	output logic [`GTE_HALF_W-1:0]  o_ir0,
	output logic [`GTE_HALF_W-1:0]  o_ir1,
	output logic [`GTE_HALF_W-1:0]  o_ir2,
	output logic [`GTE_HALF_W-1:0]  o_ir3,
	output logic [5:0]              o_leadCount,
	output logic [14:0]             o_orgb
);

	logic [5:0] wrLeadCount;  // Count of the word being written

	// Saturate one IR value to a 5-bit colour channel
	function automatic logic [4:0] packChannel(input logic [`GTE_HALF_W-1:0] ir);
		if (ir[15])
			return 5'd0;      // Negative clips to zero
		else if (|ir[14:12])
			return 5'd31;     // Overflow
		else
			return ir[11:7];
	endfunction

	gteLeadCount leadCount (
		.i_value (i_wrData),
		.o_count (wrLeadCount)
	);

	// ----------------------------------------
	// Register writes
	// ----------------------------------------
	always_ff @(posedge i_clk or negedge i_arstN) begin
		if (!i_arstN) begin
			o_sxy0      <= '0;
			o_sxy1      <= '0;
			o_sxy2      <= '0;
			o_ir0       <= '0;
			o_ir1       <= '0;
			o_ir2       <= '0;
			o_ir3       <= '0;
			o_leadCount <= '0;
		end else if (i_wr) begin
			case (i_idx)
				gteRegPkg::SXY0 : o_sxy0 <= i_wrData;  // Direct store, no shift
				gteRegPkg::SXY1 : o_sxy1 <= i_wrData;
				gteRegPkg::SXY2 : o_sxy2 <= i_wrData;
				gteRegPkg::SXYP : begin
					// Push, oldest entry drops out
					o_sxy0 <= o_sxy1;
					o_sxy1 <= o_sxy2;
					o_sxy2 <= i_wrData;
				end
				gteRegPkg::IR0  : o_ir0 <= i_wrData[`GTE_HALF_W-1:0];
				gteRegPkg::IR1  : o_ir1 <= i_wrData[`GTE_HALF_W-1:0];
				gteRegPkg::IR2  : o_ir2 <= i_wrData[`GTE_HALF_W-1:0];
				gteRegPkg::IR3  : o_ir3 <= i_wrData[`GTE_HALF_W-1:0];
				gteRegPkg::LZCS : o_leadCount <= wrLeadCount;
				default         : ;  // Held in the data file only
			endcase
		end
	end

	// Packed colour, B:G:R from IR3:IR2:IR1
	assign o_orgb = {packChannel(o_ir3), packChannel(o_ir2), packChannel(o_ir1)};

	// Head of FIFO moves only on a push or a direct SXY0 store
	sxyShiftOnPush : assert property (@(posedge i_clk) disable iff (!i_arstN)
		$changed(o_sxy0) |-> $past(i_wr) &&
			($past(i_idx) == gteRegPkg::SXYP || $past(i_idx) == gteRegPkg::SXY0))
		else $error("screen XY FIFO moved without SXYP write");

endmodule

//--- hdl/gteReadMux.sv
`include "gteReg_defines.svh"

module gteReadMux (
	input  logic                    i_clk,
	input  logic                    i_arstN,
	// Read request
	input  logic                    i_rd,
	input  gteRegPkg::gteRegAddr_t  i_regId,
	// Register file outputs, already registered
	input  logic [`GTE_WORD_W-1:0]  i_dataFile,
	input  logic [`GTE_WORD_W-1:0]  i_ctrlFile,
	// Special registers, live values
	input  logic [`GTE_WORD_W-1:0]  i_sxy0,
	input  logic [`GTE_WORD_W-1:0]  i_sxy1,
	input  logic [`GTE_WORD_W-1:0]  i_sxy2,
	input  logic [`GTE_HALF_W-1:0]  i_ir0,
	input  logic [`GTE_HALF_W-1:0]  i_ir1,
	input  logic [`GTE_HALF_W-1:0]  i_ir2,
	input  logic [`GTE_HALF_W-1:0]  i_ir3,
	input  logic [5:0]              i_leadCount,
	input  logic [14:0]             i_orgb,
	// CPU answer
	output logic [`GTE_WORD_W-1:0]  o_rdData,
	output logic                    o_rdValid
);

	gteRegPkg::gteRegAddr_t  rdId;      // ID of the last read
	gteRegPkg::gteDataReg_e  dataReg;
	logic [`GTE_WORD_W-1:0]  srcWord;   // Before promotion
	logic                    signExt;
	logic                    zeroExt;

	// ----------------------------------------
	// Request capture
	// ----------------------------------------
	always_ff @(posedge i_clk or negedge i_arstN) begin
		if (!i_arstN) begin
			rdId      <= '0;
			o_rdValid <= 1'b0;
		end else begin
			o_rdValid <= i_rd;       // One cycle per request
			if (i_rd)
				rdId <= i_regId;     // Held until next read
		end
	end

	assign dataReg = gteRegPkg::gteDataReg_e'(rdId.idx);

	// ----------------------------------------
	// Source select
	// ----------------------------------------
	always_comb begin
		if (rdId.isCtrl) begin
			srcWord = i_ctrlFile;
		end else begin
			case (dataReg)
				gteRegPkg::IR0  : srcWord = {{`GTE_HALF_W{1'b0}}, i_ir0};  // Extended below
				gteRegPkg::IR1  : srcWord = {{`GTE_HALF_W{1'b0}}, i_ir1};
				gteRegPkg::IR2  : srcWord = {{`GTE_HALF_W{1'b0}}, i_ir2};
				gteRegPkg::IR3  : srcWord = {{`GTE_HALF_W{1'b0}}, i_ir3};
				gteRegPkg::SXY0 : srcWord = i_sxy0;
				gteRegPkg::SXY1 : srcWord = i_sxy1;
				gteRegPkg::SXY2 : srcWord = i_sxy2;
				gteRegPkg::SXYP : srcWord = i_sxy2;  // Mirror, read does not pop
				gteRegPkg::IRGB,
				gteRegPkg::ORGB : srcWord = {17'd0, i_orgb};
				gteRegPkg::LZCR : srcWord = {26'd0, i_leadCount};
				default         : srcWord = i_dataFile;
			endcase
		end
	end

	// ----------------------------------------
	// Upper half promotion
	// ----------------------------------------
	always_comb begin
		if (rdId.isCtrl) begin
			signExt = (rdId.idx == `GTE_CT_R33) || (rdId.idx == `GTE_CT_L33) ||
				(rdId.idx == `GTE_CT_LB3);
			zeroExt = (rdId.idx >= `GTE_CT_ZLO) && (rdId.idx <= `GTE_CT_ZHI);
		end else begin
			// VZ0..VZ2 and IR0..IR3 are signed 16-bit
			signExt = (dataReg == gteRegPkg::VZ0) || (dataReg == gteRegPkg::VZ1) ||
				(dataReg == gteRegPkg::VZ2) ||
				(dataReg >= gteRegPkg::IR0 && dataReg <= gteRegPkg::IR3);
			// OTZ and SZ0..SZ3 are unsigned 16-bit
			zeroExt = (dataReg == gteRegPkg::OTZ) ||
				(dataReg >= gteRegPkg::SZ0 && dataReg <= gteRegPkg::SZ3);
		end
	end

	always_comb begin
		if (signExt)
			o_rdData = {{`GTE_HALF_W{srcWord[`GTE_HALF_W-1]}}, srcWord[`GTE_HALF_W-1:0]};
		else if (zeroExt)
			o_rdData = {{`GTE_HALF_W{1'b0}}, srcWord[`GTE_HALF_W-1:0]};
		else
			o_rdData = srcWord;  // Full word
	end

endmodule

//--- hdl/gteRegTop.sv
`include "gteReg_defines.svh"

module gteRegTop (
	input  logic                   i_clk,
	input  logic                   i_arstN,
	// CPU register port
	input  logic [5:0]             i_regId,
	input  logic                   i_wrReg,
	input  logic                   i_rdReg,
	input  logic [`GTE_WORD_W-1:0] i_wrData,
	output logic [`GTE_WORD_W-1:0] o_rdData,
	output logic                   o_rdValid
);

	gteRegPkg::gteRegAddr_t  regAddr;
	gteRegPkg::gteDataReg_e  dataIdx;
	logic                    dataWr, ctrlWr;
	logic                    dataRd, ctrlRd;
	logic [`GTE_WORD_W-1:0]  dataWord, ctrlWord;
	logic [`GTE_WORD_W-1:0]  sxy0, sxy1, sxy2;
	logic [`GTE_HALF_W-1:0]  ir0, ir1, ir2, ir3;
	logic [5:0]              leadCount;
	logic [14:0]             orgb;

	// ----------------------------------------
	// Address split
	// ----------------------------------------
	assign regAddr = i_regId;
	assign dataIdx = gteRegPkg::gteDataReg_e'(regAddr.idx);
	assign dataWr  = i_wrReg & ~regAddr.isCtrl;
	assign ctrlWr  = i_wrReg &  regAddr.isCtrl;
	assign dataRd  = i_rdReg & ~regAddr.isCtrl;
	assign ctrlRd  = i_rdReg &  regAddr.isCtrl;

	gteRegFile dataFile (
		.i_clk    (i_clk),
		.i_rd     (dataRd), .i_rdIdx (regAddr.idx), .o_rdData (dataWord),
		.i_wr     (dataWr), .i_wrIdx (regAddr.idx), .i_wrData (i_wrData)
	);

	gteRegFile ctrlFile (
		.i_clk    (i_clk),
		.i_rd     (ctrlRd), .i_rdIdx (regAddr.idx), .o_rdData (ctrlWord),
		.i_wr     (ctrlWr), .i_wrIdx (regAddr.idx), .i_wrData (i_wrData)
	);

	// Sees every data write, keeps only its own indices
	gteSpecialRegs specialRegs (
		.i_clk       (i_clk),     .i_arstN (i_arstN),
		.i_wr        (dataWr),    .i_idx   (dataIdx), .i_wrData (i_wrData),
		.o_sxy0      (sxy0),      .o_sxy1  (sxy1),    .o_sxy2   (sxy2),
		.o_ir0       (ir0),       .o_ir1   (ir1),     .o_ir2    (ir2),    .o_ir3 (ir3),
		.o_leadCount (leadCount), .o_orgb  (orgb)
	);

	gteReadMux readMux (
		.i_clk       (i_clk),     .i_arstN    (i_arstN),
		.i_rd        (i_rdReg),   .i_regId    (regAddr),
		.i_dataFile  (dataWord),  .i_ctrlFile (ctrlWord),
		.i_sxy0      (sxy0),      .i_sxy1     (sxy1),    .i_sxy2 (sxy2),
		.i_ir0       (ir0),       .i_ir1      (ir1),     .i_ir2  (ir2),   .i_ir3 (ir3),
		.i_leadCount (leadCount), .i_orgb     (orgb),
		.o_rdData    (o_rdData),  .o_rdValid  (o_rdValid)
	);

	// CPU never reads and writes in one cycle
	noRdWrOverlap : assert property (@(posedge i_clk) disable iff (!i_arstN)
		!(i_wrReg && i_rdReg))
		else $error("read and write requested in the same cycle");

endmodule

//--- verif/gteRegTb.sv
module gteRegTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CYCLE_LIMIT = 2000;  // Generous margin over the stimulus length

	logic        clk, arstN;
	logic [5:0]  regId;
	logic        wrReg, rdReg;
	logic [31:0] wrData, rdData;
	logic        rdValid;

	// Shadow model of the register block
	logic [31:0] dataModel [32];
	logic [31:0] ctrlModel [32];
	logic [31:0] sxyModel [3];
	logic [15:0] irModel [4];
	logic [5:0]  leadModel;
	logic [31:0] expData;   // Expected answer of the pending read
	logic [5:0]  lastId;
	logic [31:0] rngState;
	int          readErrors, timingErrors, resetErrors, cycleCount;

	// IR levels: negative, overflowing and in range
	logic [15:0] colourLevels [6] = '{16'h8123, 16'hF000, 16'h1000, 16'h7FFF,
		16'h0F80, 16'h0380};
	logic [31:0] leadEdges [6] = '{32'h0, 32'hFFFFFFFF, 32'h80000000, 32'h7FFFFFFF,
		32'h00000001, 32'hFFFFFFFE};

	gteRegTop DUT (
		.i_clk (clk), .i_arstN (arstN), .i_regId (regId),
		.i_wrReg (wrReg), .i_rdReg (rdReg), .i_wrData (wrData),
		.o_rdData (rdData), .o_rdValid (rdValid)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] nextRandom();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	function automatic logic [31:0] signHalf(input logic [31:0] w);
		return {{16{w[15]}}, w[15:0]};
	endfunction

	// Run of leading copies of bit 31, bit 31 included
	function automatic logic [5:0] leadBits(input logic [31:0] v);
		logic [31:0] t;
		int          n;
		t = v;
		n = 1;
		while (n < 32 && t[30] == v[31]) begin
			t = t << 1;
			n++;
		end
		return 6'(n);
	endfunction

	function automatic logic [4:0] clampChannel(input logic [15:0] ir);
		if (ir[15])
			return 5'd0;
		if (ir[14:12] != 3'd0)
			return 5'd31;  // Saturated
		return ir[11:7];
	endfunction

	function automatic logic [31:0] expectedWord(input logic [5:0] id);
		logic [4:0] idx;
		idx = id[4:0];
		if (id[5]) begin
			if (idx == 5'd4 || idx == 5'd12 || idx == 5'd20)
				return signHalf(ctrlModel[idx]);
			if (idx >= 5'd26 && idx <= 5'd30)
				return {16'd0, ctrlModel[idx][15:0]};
			return ctrlModel[idx];
		end
		case (idx)
			5'd1, 5'd3, 5'd5            : return signHalf(dataModel[idx]);  // VZ0..VZ2
			5'd7, 5'd16, 5'd17, 5'd18, 5'd19 : return {16'd0, dataModel[idx][15:0]};
			5'd8, 5'd9, 5'd10, 5'd11    : return signHalf({16'd0, irModel[2'(idx - 5'd8)]});
			5'd12, 5'd13, 5'd14         : return sxyModel[2'(idx - 5'd12)];
			5'd15                       : return sxyModel[2];  // SXYP mirrors SXY2
			5'd28, 5'd29                : return {17'd0, clampChannel(irModel[3]),
				clampChannel(irModel[2]), clampChannel(irModel[1])};
			5'd31                       : return {26'd0, leadModel};
			default                     : return dataModel[idx];
		endcase
	endfunction

	// ----------------------------------------
	// CPU port tasks, falling edge drive
	// ----------------------------------------
	task automatic writeReg(input logic [5:0] id, input logic [31:0] value);
		@(negedge clk);
		regId  = id;
		wrData = value;
		wrReg  = 1'b1;
		rdReg  = 1'b0;
		if (id[5]) begin
			ctrlModel[id[4:0]] = value;
		end else begin
			dataModel[id[4:0]] = value;
			case (id[4:0])
				5'd8, 5'd9, 5'd10, 5'd11 : irModel[2'(id[4:0] - 5'd8)] = value[15:0];
				5'd12, 5'd13, 5'd14      : sxyModel[2'(id[4:0] - 5'd12)] = value;
				5'd15 : begin
					sxyModel[0] = sxyModel[1];  // FIFO push
					sxyModel[1] = sxyModel[2];
					sxyModel[2] = value;
				end
				5'd30   : leadModel = leadBits(value);
				default : ;
			endcase
		end
	endtask

	// Request, then one idle cycle while the answer is checked
	task automatic readReg(input logic [5:0] id);
		@(negedge clk);
		regId   = id;
		wrReg   = 1'b0;
		rdReg   = 1'b1;
		lastId  = id;
		expData = expectedWord(id);
		@(negedge clk);
		rdReg = 1'b0;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clk);
			wrReg = 1'b0;
			rdReg = 1'b0;
		end
	endtask

	task automatic checkPromotion(input logic [5:0] id);
		writeReg(id, 32'hA5A58001);  // Bit 15 set
		readReg(id);
		writeReg(id, 32'h5A5A7FFE);
		readReg(id);
	endtask

	// ----------------------------------------
	// Checks
	// ----------------------------------------
	readDataMatch : assert property (@(posedge clk) disable iff (!arstN)
		rdValid |-> rdData == expData)
		else begin
			readErrors++;
			$display("[ERROR] %0t: read of ID %0d returned %h, expected %h",
				$time, lastId, $sampled(rdData), expData);
		end

	validAfterRead : assert property (@(posedge clk) disable iff (!arstN)
		rdReg |=> rdValid)
		else begin
			timingErrors++;
			$display("[ERROR] %0t: o_rdValid low in the cycle after a read request", $time);
		end

	noValidWithoutRead : assert property (@(posedge clk) disable iff (!arstN)
		!rdReg |=> !rdValid)
		else begin
			timingErrors++;
			$display("[ERROR] %0t: o_rdValid high without a read request", $time);
		end

	validLowOutOfReset : assert property (@(posedge clk) $rose(arstN) |-> !rdValid)
		else begin
			resetErrors++;
			$display("[ERROR] %0t: o_rdValid high at reset release", $time);
		end

	initial begin
		cycleCount = 0;
		while (cycleCount < CYCLE_LIMIT) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: stimulus still running after %0d cycles", CYCLE_LIMIT);
		$display("sim failed");
		$finish;
	end

	initial begin
		logic [31:0] word;
		clk = 1'b0;
		arstN = 1'b0;
		regId = '0;
		wrReg = 1'b0;
		rdReg = 1'b0;
		wrData = '0;
		rngState = 32'd35;
		expData = '0;
		lastId = '0;
		leadModel = '0;  // Special registers clear on reset
		readErrors = 0;
		timingErrors = 0;
		resetErrors = 0;
		for (int i = 0; i < 3; i++)
			sxyModel[i] = '0;
		for (int i = 0; i < 4; i++)
			irModel[i] = '0;
		repeat (10) @(negedge clk);
		arstN = 1'b1;
		idle(5);  // No reads yet, valid stays low

		// Round trip over every control and plain data register
		for (int i = 0; i < 32; i++) begin
			writeReg({1'b1, 5'(i)}, nextRandom());
			readReg({1'b1, 5'(i)});
		end
		for (int i = 0; i < 28; i++) begin
			if (i < 8 || i > 15) begin
				writeReg({1'b0, 5'(i)}, nextRandom());
				readReg({1'b0, 5'(i)});
			end
		end

		// Sign and zero promotion
		checkPromotion(6'd1);
		checkPromotion(6'd3);
		checkPromotion(6'd5);
		checkPromotion(6'd7);
		for (int i = 8; i < 12; i++)
			checkPromotion(6'(i));  // IR0..IR3
		for (int i = 16; i < 20; i++)
			checkPromotion(6'(i));  // SZ0..SZ3
		checkPromotion({1'b1, 5'd4});
		checkPromotion({1'b1, 5'd12});
		checkPromotion({1'b1, 5'd20});
		for (int i = 26; i < 31; i++)
			checkPromotion({1'b1, 5'(i)});

		// Screen XY FIFO
		for (int i = 0; i < 3; i++)
			writeReg(6'd15, nextRandom());
		for (int i = 12; i < 16; i++)
			readReg(6'(i));
		writeReg(6'd13, nextRandom());  // Direct store to SXY1
		for (int i = 12; i < 15; i++)
			readReg(6'(i));
		writeReg(6'd15, nextRandom());
		for (int i = 12; i < 16; i++)
			readReg(6'(i));

		// Packed colour, fixed levels then random words
		for (int k = 0; k < 10; k++) begin
			for (int c = 1; c <= 3; c++) begin
				word = nextRandom();
				if (k < 6)
					word[15:0] = colourLevels[(k + 2 * c) % 6];
				writeReg(6'(8 + c), word);  // IR1..IR3
			end
			readReg(6'd28);
			readReg(6'd29);
		end

		// Lead count
		for (int k = 0; k < 14; k++) begin
			if (k < 6) begin
				word = leadEdges[k];
			end else begin
				word = nextRandom();
				word = 32'($signed(word) >>> word[4:0]);  // Longer sign runs
			end
			writeReg(6'd30, word);
			readReg(6'd31);
			readReg(6'd30);
		end

		idle(3);
		$display("Errors: read data %0d, read timing %0d, reset %0d",
			readErrors, timingErrors, resetErrors);
		if (readErrors + timingErrors + resetErrors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

//--- sources.f
+incdir+hdl
hdl/gteRegPkg.sv
hdl/gteRegFile.sv
hdl/gteLeadCount.sv
hdl/gteSpecialRegs.sv
hdl/gteReadMux.sv
hdl/gteRegTop.sv
verif/gteRegTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module gteRegTb -o gteRegSim

./obj_dir/gteRegSim > sim.log 2>&1
cat sim.log

if grep -q "sim failed" sim.log; then
	exit 1
fi
exit 0
